// File: Makefile
# Verilator build and run of the FX3 stream master testbench

VERILATOR ?= verilator
TOP       ?= tb_fx3_stream_master
FILELIST  ?= fx3_stream_master.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(VERILATOR), run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '^>>> PASS$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/fx3_capture.sv
module fx3_capture (
    input  logic                     usb_clk,
    input  logic                     reset_,
    input  logic [3:0]               flag_i,
    input  stream_pkg::word_t        data_i,
    output fx3_pins_pkg::fx3_flags_t cap_flags_o,
    output stream_pkg::word_t        cap_data_o
);

    // flag bit order on the pins
    // flag_i[0] flaga, [1] flagb, [2] flagc, [3] flagd
    fx3_pins_pkg::fx3_flags_t flags_pin;

    always_comb begin
        flags_pin.flaga = flag_i[0];
        flags_pin.flagb = flag_i[1];
        flags_pin.flagc = flag_i[2];
        flags_pin.flagd = flag_i[3];
    end

    // flags come from another chip, so flop them once
    // low after reset keeps the controller parked in idle
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            cap_flags_o <= '0;
        end else begin
            cap_flags_o <= flags_pin;
        end
    end

    // inbound bus, sampled every cycle
    // the controller decides which samples are real read data
    always_ff @(posedge usb_clk) begin
        cap_data_o <= data_i;
    end

endmodule

// File: design/fx3_drive.sv
module fx3_drive (
    input  logic                       usb_clk,
    input  logic                       reset_,
    input  fx3_pins_pkg::fx3_strobes_t strobes_i,
    input  fx3_pins_pkg::fx3_addr_t    addr_i,
    input  stream_pkg::word_t          wr_data_i,
    output logic                       slcs_o,
    output logic                       slrd_o,
    output logic                       sloe_o,
    output logic                       slwr_o,
    output fx3_pins_pkg::fx3_addr_t    fifo_addr_o,
    output stream_pkg::word_t          data_o,
    output logic                       data_oe_o
);

    fx3_pins_pkg::fx3_strobes_t strobes_q;

    // all strobes inactive and socket parked after reset
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            strobes_q   <= '1;
            fifo_addr_o <= fx3_pins_pkg::FIFO_ADDR_IDLE;
        end else begin
            strobes_q   <= strobes_i;
            fifo_addr_o <= addr_i;
        end
    end

    // write word leaves together with its slwr low
    // holds the last word between writes
    always_ff @(posedge usb_clk) begin
        if (!strobes_i.slwr) begin
            data_o <= wr_data_i;
        end
    end

    assign slcs_o = strobes_q.slcs;
    assign slrd_o = strobes_q.slrd;
    assign sloe_o = strobes_q.sloe;
    assign slwr_o = strobes_q.slwr;

    // we own the bus only during a write cycle
    assign data_oe_o = !strobes_q.slwr;

endmodule

// File: design/fx3_pins_pkg.sv
package fx3_pins_pkg;

    // fx3 level flags as seen after the capture register
    // flaga/flagb gate stream-in writes, flagc/flagd start stream-out
    typedef struct packed {
        logic flaga;
        logic flagb;
        logic flagc;
        logic flagd;
    } fx3_flags_t;

    // slave fifo control strobes, all active low
    typedef struct packed {
        logic slcs;
        logic slrd;
        logic sloe;
        logic slwr;
    } fx3_strobes_t;

    // a1:a0 socket select
    typedef logic [1:0] fx3_addr_t;

    // host to fpga socket
    localparam fx3_addr_t FIFO_ADDR_STREAM_OUT = 2'd3;

    // fpga to host socket
    localparam fx3_addr_t FIFO_ADDR_STREAM_IN = 2'd0;

    // parked address while no socket is in use
    localparam fx3_addr_t FIFO_ADDR_IDLE = 2'd2;

endpackage

// File: design/fx3_stream_master.sv
module fx3_stream_master #(
    parameter int BUF_ADDR_BITS = 12,
    parameter int RD_LATENCY    = 2
) (
    input  logic                    usb_clk,
    input  logic                    reset_,
    input  logic [3:0]              flag_i,
    input  stream_pkg::word_t       data_i,
    output logic                    slcs_o,
    output logic                    slrd_o,
    output logic                    sloe_o,
    output logic                    slwr_o,
    output fx3_pins_pkg::fx3_addr_t fifo_addr_o,
    output stream_pkg::word_t       data_o,
    output logic                    data_oe_o
);

    fx3_pins_pkg::fx3_flags_t   cap_flags;
    stream_pkg::word_t          cap_data;
    fx3_pins_pkg::fx3_strobes_t strobes_nxt;
    fx3_pins_pkg::fx3_addr_t    addr_nxt;
    logic                       buf_push;
    logic                       buf_pop;
    logic                       buf_full;
    logic                       buf_empty;
    stream_pkg::word_t          push_data;
    stream_pkg::word_t          pop_data;

    // pin sampling stage
    fx3_capture u_capture (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .flag_i      (flag_i),
        .data_i      (data_i),
        .cap_flags_o (cap_flags),
        .cap_data_o  (cap_data)
    );

    // transaction fsm and read alignment
    transfer_ctrl #(
        .BUF_ADDR_BITS (BUF_ADDR_BITS),
        .RD_LATENCY    (RD_LATENCY)
    ) u_ctrl (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .cap_flags_i (cap_flags),
        .cap_data_i  (cap_data),
        .buf_full_i  (buf_full),
        .buf_empty_i (buf_empty),
        .strobes_o   (strobes_nxt),
        .addr_o      (addr_nxt),
        .buf_push_o  (buf_push),
        .push_data_o (push_data),
        .buf_pop_o   (buf_pop)
    );

    // one block between stream-out and stream-in
    word_buffer #(
        .BUF_ADDR_BITS (BUF_ADDR_BITS)
    ) u_buffer (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .push_i      (buf_push),
        .push_data_i (push_data),
        .pop_i       (buf_pop),
        .pop_data_o  (pop_data),
        .full_o      (buf_full),
        .empty_o     (buf_empty)
    );

    // registered pin outputs
    fx3_drive u_drive (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .strobes_i   (strobes_nxt),
        .addr_i      (addr_nxt),
        .wr_data_i   (pop_data),
        .slcs_o      (slcs_o),
        .slrd_o      (slrd_o),
        .sloe_o      (sloe_o),
        .slwr_o      (slwr_o),
        .fifo_addr_o (fifo_addr_o),
        .data_o      (data_o),
        .data_oe_o   (data_oe_o)
    );

endmodule

// File: design/stream_pkg.sv
package stream_pkg;

    // width of the fx3 gpif data bus
    localparam int WORD_BITS = 32;

    // one bus word, as read from or written to the fx3
    typedef logic [WORD_BITS-1:0] word_t;

    // transaction phases of the master
    // idle          waits for the host to offer a block
    // stream_out    issues the block reads
    // wait_fill     lets the trailing read data land in the buffer
    // stream_in     writes the block back to the host
    typedef enum logic [1:0] {
        xfer_idle       = 2'd0,
        xfer_stream_out = 2'd1,
        xfer_wait_fill  = 2'd2,
        xfer_stream_in  = 2'd3
    } xfer_state_t;

endpackage

// File: design/transfer_ctrl.sv
module transfer_ctrl #(
    parameter int BUF_ADDR_BITS = 12,
    parameter int RD_LATENCY    = 2
) (
    input  logic                       usb_clk,
    input  logic                       reset_,
    input  fx3_pins_pkg::fx3_flags_t   cap_flags_i,
    input  stream_pkg::word_t          cap_data_i,
    input  logic                       buf_full_i,
    input  logic                       buf_empty_i,
    output fx3_pins_pkg::fx3_strobes_t strobes_o,
    output fx3_pins_pkg::fx3_addr_t    addr_o,
    output logic                       buf_push_o,
    output stream_pkg::word_t          push_data_o,
    output logic                       buf_pop_o
);

    // drive flop + fx3 read latency + capture flop
    localparam int HIST_DEPTH = RD_LATENCY + 2;

    // read index of the last word in a block
    localparam logic [BUF_ADDR_BITS-1:0] RD_LAST = '1;

    stream_pkg::xfer_state_t state;
    stream_pkg::xfer_state_t state_nxt;

    // reads issued so far in this block
    logic [BUF_ADDR_BITS-1:0] rd_cnt;

    // one bit per issued read, shifted until its data is captured
    logic [HIST_DEPTH-1:0] rd_hist;

    logic rd_issue;
    logic wr_go;

    // read strobes for the whole stream_out phase, one word per cycle
    assign rd_issue = (state == stream_pkg::xfer_stream_out);

    // write only while the fx3 has room and there is a word to send
    assign wr_go = (state == stream_pkg::xfer_stream_in) &&
                   cap_flags_i.flaga && cap_flags_i.flagb && !buf_empty_i;

    always_comb begin
        state_nxt = state;
        case (state)
            stream_pkg::xfer_idle: begin
                // host has a block ready on the stream-out socket
                if (cap_flags_i.flagc && cap_flags_i.flagd) begin
                    state_nxt = stream_pkg::xfer_stream_out;
                end
            end
            stream_pkg::xfer_stream_out: begin
                if (rd_cnt == RD_LAST) begin
                    state_nxt = stream_pkg::xfer_wait_fill;
                end
            end
            stream_pkg::xfer_wait_fill: begin
                // last reads are still in flight through the pipeline
                if (buf_full_i) begin
                    state_nxt = stream_pkg::xfer_stream_in;
                end
            end
            stream_pkg::xfer_stream_in: begin
                if (buf_empty_i) begin
                    state_nxt = stream_pkg::xfer_idle;
                end
            end
            default: begin
                state_nxt = stream_pkg::xfer_idle;
            end
        endcase
    end

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            state <= stream_pkg::xfer_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // wraps back to zero after the last read of the block
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            rd_cnt <= '0;
        end else if (rd_issue) begin
            rd_cnt <= rd_cnt + 1'b1;
        end
    end

    // strobe history lines each captured word up with its read
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            rd_hist <= '0;
        end else begin
            rd_hist <= {rd_hist[HIST_DEPTH-2:0], rd_issue};
        end
    end

    // oldest history bit marks a valid word on cap_data_i
    assign buf_push_o  = rd_hist[HIST_DEPTH-1];
    assign push_data_o = cap_data_i;
    assign buf_pop_o   = wr_go;

    // pin levels for the next cycle, registered in fx3_drive
    always_comb begin
        strobes_o.slcs = (state == stream_pkg::xfer_idle);
        strobes_o.slrd = !rd_issue;
        strobes_o.sloe = !rd_issue;
        strobes_o.slwr = !wr_go;
    end

    always_comb begin
        case (state)
            stream_pkg::xfer_stream_out: addr_o = fx3_pins_pkg::FIFO_ADDR_STREAM_OUT;
            stream_pkg::xfer_stream_in:  addr_o = fx3_pins_pkg::FIFO_ADDR_STREAM_IN;
            default:                     addr_o = fx3_pins_pkg::FIFO_ADDR_IDLE;
        endcase
    end

endmodule

// File: design/word_buffer.sv
module word_buffer #(
    parameter int BUF_ADDR_BITS = 12
) (
    input  logic              usb_clk,
    input  logic              reset_,
    input  logic              push_i,
    input  stream_pkg::word_t push_data_i,
    input  logic              pop_i,
    output stream_pkg::word_t pop_data_o,
    output logic              full_o,
    output logic              empty_o
);

    localparam int DEPTH = 1 << BUF_ADDR_BITS;

    stream_pkg::word_t mem [DEPTH];

    // extra msb tells a full buffer from an empty one
    logic [BUF_ADDR_BITS:0] wr_ptr;
    logic [BUF_ADDR_BITS:0] rd_ptr;

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage only, contents are meaningless until pushed
    always_ff @(posedge usb_clk) begin
        if (push_i) begin
            mem[wr_ptr[BUF_ADDR_BITS-1:0]] <= push_data_i;
        end
    end

    // head word is visible in the pop cycle itself
    assign pop_data_o = mem[rd_ptr[BUF_ADDR_BITS-1:0]];

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[BUF_ADDR_BITS] != rd_ptr[BUF_ADDR_BITS]) &&
                     (wr_ptr[BUF_ADDR_BITS-1:0] == rd_ptr[BUF_ADDR_BITS-1:0]);

    // controller must issue no more reads than one block holds
    a_no_push_full: assert property (
        @(posedge usb_clk) disable iff (!reset_)
        push_i |-> !full_o
    );

    // stream-in writes are gated on a non-empty buffer
    a_no_pop_empty: assert property (
        @(posedge usb_clk) disable iff (!reset_)
        pop_i |-> !empty_o
    );

endmodule

// File: fx3_stream_master.f
design/fx3_pins_pkg.sv
design/stream_pkg.sv
design/fx3_capture.sv
design/transfer_ctrl.sv
design/word_buffer.sv
design/fx3_drive.sv
design/fx3_stream_master.sv
verification/fx3_checker.sv
verification/tb_fx3_stream_master.sv

// File: verification/fx3_checker.sv
module fx3_checker #(
    parameter int BLOCK_WORDS    = 16,
    parameter int TIMEOUT_CYCLES = 240
) (
    input  logic                    usb_clk,
    input  logic                    reset_,
    input  logic [3:0]              fx3_flag_i,
    input  logic                    slcs_i,
    input  logic                    slrd_i,
    input  logic                    sloe_i,
    input  logic                    slwr_i,
    input  fx3_pins_pkg::fx3_addr_t fifo_addr_i,
    input  stream_pkg::word_t       wr_data_i,
    input  logic                    data_oe_i,
    input  logic                    test_start_i,
    input  int                      test_num_i,
    input  stream_pkg::word_t       exp_block_i [BLOCK_WORDS],
    output logic                    test_done_o,
    output logic                    timed_out_o,
    output int                      pass_cnt_o,
    output int                      fail_cnt_o
);

    logic  active;
    logic  seen_busy;
    logic  reset_checked;
    int    rd_cnt;
    int    wr_cnt;
    // cycles in a row with flaga or flagb low at the pins
    int    low_run;
    int    errs;
    int    cycle_cnt;
    string name;

    function automatic string test_name(input int num);
        case (num)
            0:       return "no_stall";
            1:       return "sparse_stall";
            default: return "burst_stall";
        endcase
    endfunction

    task automatic value_error(input string what, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        $display("** Error %s: %s expected %0h actual %0h", name, what, exp_val, act_val);
        errs++;
    endtask

    task automatic close_test();
        if (errs == 0) begin
            $display("test %s: passed", name);
            pass_cnt_o++;
        end else begin
            $display("test %s: failed with %0d errors", name, errs);
            fail_cnt_o++;
        end
    endtask

    // pins right after reset, before the fx3 offers anything
    task automatic check_reset_state();
        name = "reset_state";
        errs = 0;
        if ({slcs_i, slrd_i, sloe_i, slwr_i} !== 4'hf) begin
            value_error("slcs/slrd/sloe/slwr", 32'hf, 32'({slcs_i, slrd_i, sloe_i, slwr_i}));
        end
        if (data_oe_i !== 1'b0) begin
            value_error("data_oe_o", 32'd0, 32'(data_oe_i));
        end
        if (fifo_addr_i !== fx3_pins_pkg::FIFO_ADDR_IDLE) begin
            value_error("fifo_addr_o", 32'd2, 32'(fifo_addr_i));
        end
        close_test();
    endtask

    task automatic check_read();
        rd_cnt++;
        if (rd_cnt > BLOCK_WORDS) begin
            $display("%s: read number %0d goes past the end of the block", name, rd_cnt);
            errs++;
        end
        if (sloe_i !== 1'b0) begin
            value_error("sloe_o during read", 32'd0, 32'(sloe_i));
        end
        if (fifo_addr_i !== fx3_pins_pkg::FIFO_ADDR_STREAM_OUT) begin
            value_error("fifo_addr_o during read", 32'd3, 32'(fifo_addr_i));
        end
    endtask

    // echo must come back in order, one word per write
    task automatic check_write();
        if (wr_cnt < BLOCK_WORDS) begin
            if (wr_data_i !== exp_block_i[wr_cnt]) begin
                value_error($sformatf("echo word %0d", wr_cnt), exp_block_i[wr_cnt], wr_data_i);
            end
        end else begin
            $display("%s: extra write after the whole block was sent", name);
            errs++;
        end
        if (fifo_addr_i !== fx3_pins_pkg::FIFO_ADDR_STREAM_IN) begin
            value_error("fifo_addr_o during write", 32'd0, 32'(fifo_addr_i));
        end
        if (data_oe_i !== 1'b1) begin
            value_error("data_oe_o during write", 32'd1, 32'(data_oe_i));
        end
        // two writes may still be in the pipeline when the fx3 fills up
        if (low_run > 2) begin
            $display("%s: write issued %0d cycles into an fx3 stall", name, low_run);
            errs++;
        end
        wr_cnt++;
    endtask

    // sample on the falling edge, where pins and model inputs are settled
    always @(negedge usb_clk) begin
        if (!reset_) begin
            active        = 1'b0;
            seen_busy     = 1'b0;
            reset_checked = 1'b0;
            test_done_o   = 1'b0;
            timed_out_o   = 1'b0;
            pass_cnt_o    = 0;
            fail_cnt_o    = 0;
            cycle_cnt     = 0;
            errs          = 0;
        end else begin
            cycle_cnt++;
            if (cycle_cnt == TIMEOUT_CYCLES) begin
                $display("timeout: %0d cycles passed and the tests did not finish", cycle_cnt);
                timed_out_o = 1'b1;
            end
            if (!reset_checked) begin
                check_reset_state();
                reset_checked = 1'b1;
            end
            if (test_start_i) begin
                name        = test_name(test_num_i);
                active      = 1'b1;
                seen_busy   = 1'b0;
                test_done_o = 1'b0;
                rd_cnt      = 0;
                wr_cnt      = 0;
                low_run     = 0;
                errs        = 0;
            end
            if (fx3_flag_i[0] && fx3_flag_i[1]) begin
                low_run = 0;
            end else begin
                low_run++;
            end
            if (!slwr_i && !sloe_i) begin
                $display("slwr_o and sloe_o are both low in the same cycle");
                errs++;
                if (!active) begin
                    fail_cnt_o++;
                end
            end
            if (active) begin
                if (!slcs_i) begin
                    seen_busy = 1'b1;
                end
                if (!slrd_i) begin
                    check_read();
                end
                if (!slwr_i) begin
                    check_write();
                end
                // bus released whenever no write is on the pins
                if (slwr_i && data_oe_i !== 1'b0) begin
                    value_error("data_oe_o outside a write", 32'd0, 32'(data_oe_i));
                end
                // chip select back high closes the transaction
                if (seen_busy && slcs_i) begin
                    if (rd_cnt != BLOCK_WORDS) begin
                        value_error("read count", 32'(BLOCK_WORDS), 32'(rd_cnt));
                    end
                    if (wr_cnt != BLOCK_WORDS) begin
                        value_error("write count", 32'(BLOCK_WORDS), 32'(wr_cnt));
                    end
                    close_test();
                    active      = 1'b0;
                    test_done_o = 1'b1;
                end
            end
        end
    end

endmodule

// File: verification/fx3_stream_stimulus.txt
// per test: stall mask word (bit 0 first, 1 = fx3 has room), then 16 block words
// hex values, read in order by the testbench
// test 0 no stalls
ffffffff
11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888
99999999 aaaaaaaa bbbbbbbb cccccccc dddddddd eeeeeeee ffffffff 00000000
// test 1 single cycle stalls
f7defbef
deadbeef cafef00d 0badc0de 8badf00d feedface 12345678 9abcdef0 0f0f0f0f
f0f0f0f0 a5a5a5a5 5a5a5a5a 00ff00ff ff00ff00 13579bdf 2468ace0 c001d00d
// test 2 burst stalls
ff00fc3f
00000001 00000004 00000010 00000040 00000100 00000400 00001000 00004000
00010000 00040000 00100000 00400000 01000000 04000000 10000000 40000000

// File: verification/tb_fx3_stream_master.sv
module tb_fx3_stream_master;

    localparam int BUF_ADDR_BITS = 4;
    localparam int RD_LATENCY    = 2;
    localparam int BLOCK_WORDS   = 1 << BUF_ADDR_BITS;
    localparam int NUM_TESTS     = 3;
    localparam int MASK_BITS     = 32;
    // stall mask word plus the block
    localparam int TEST_WORDS    = BLOCK_WORDS + 1;
    // reads and writes, every mask bit, and slack for start and return to idle
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (2 * BLOCK_WORDS + MASK_BITS + 16);

    logic                    usb_clk;
    logic                    reset_;
    logic                    flag_ab;
    logic                    flag_cd;
    logic [3:0]              flag_i;
    stream_pkg::word_t       data_i;
    logic                    slcs;
    logic                    slrd;
    logic                    sloe;
    logic                    slwr;
    fx3_pins_pkg::fx3_addr_t fifo_addr;
    stream_pkg::word_t       data_out;
    logic                    data_oe;

    stream_pkg::word_t       stim_mem [NUM_TESTS * TEST_WORDS];
    stream_pkg::word_t       exp_block [BLOCK_WORDS];
    logic [MASK_BITS-1:0]    stall_mask;
    logic [31:0]             rng;
    // reads seen at the pins, waiting for the fx3 latency
    logic [RD_LATENCY-1:0]   rd_pend;
    int                      mask_left;
    int                      rd_seen;
    int                      rd_idx;
    int                      wr_seen;
    int                      test_num;
    logic                    test_start;
    logic                    test_done;
    logic                    timed_out;
    int                      pass_cnt;
    int                      fail_cnt;

    // flaga/flagb gate writes, flagc/flagd offer a block
    assign flag_i = {flag_cd, flag_cd, flag_ab, flag_ab};

    fx3_stream_master #(
        .BUF_ADDR_BITS (BUF_ADDR_BITS),
        .RD_LATENCY    (RD_LATENCY)
    ) UUT (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .flag_i      (flag_i),
        .data_i      (data_i),
        .slcs_o      (slcs),
        .slrd_o      (slrd),
        .sloe_o      (sloe),
        .slwr_o      (slwr),
        .fifo_addr_o (fifo_addr),
        .data_o      (data_out),
        .data_oe_o   (data_oe)
    );

    fx3_checker #(
        .BLOCK_WORDS    (BLOCK_WORDS),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_checker (
        .usb_clk      (usb_clk),
        .reset_       (reset_),
        .fx3_flag_i   (flag_i),
        .slcs_i       (slcs),
        .slrd_i       (slrd),
        .sloe_i       (sloe),
        .slwr_i       (slwr),
        .fifo_addr_i  (fifo_addr),
        .wr_data_i    (data_out),
        .data_oe_i    (data_oe),
        .test_start_i (test_start),
        .test_num_i   (test_num),
        .exp_block_i  (exp_block),
        .test_done_o  (test_done),
        .timed_out_o  (timed_out),
        .pass_cnt_o   (pass_cnt),
        .fail_cnt_o   (fail_cnt)
    );

    initial begin
        usb_clk = 1'b0;
        forever begin
            #2 usb_clk = ~usb_clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // fx3 side of one clock, driven just after the rising edge
    task automatic bus_cycle();
        @(posedge usb_clk);
        #1;
        // read data shows up RD_LATENCY cycles after slrd low, noise otherwise
        if (rd_pend[RD_LATENCY-1] && rd_idx < BLOCK_WORDS) begin
            data_i = exp_block[rd_idx];
            rd_idx++;
        end else begin
            rng    = xorshift32(rng);
            data_i = rng;
        end
        rd_pend    = rd_pend << 1;
        rd_pend[0] = !slrd;
        if (!slrd) begin
            rd_seen++;
            flag_cd = 1'b0;
        end
        if (!slwr) begin
            wr_seen++;
        end
        // stall mask plays out once the block is read, until all words are back
        if (rd_seen >= BLOCK_WORDS && wr_seen < BLOCK_WORDS && mask_left > 0) begin
            flag_ab    = stall_mask[0];
            stall_mask = stall_mask >> 1;
            mask_left--;
        end else begin
            flag_ab = 1'b1;
        end
    endtask

    initial begin
        reset_     = 1'b0;
        flag_ab    = 1'b1;
        flag_cd    = 1'b0;
        data_i     = '0;
        test_start = 1'b0;
        test_num   = 0;
        rng        = 32'd85093;
        rd_pend    = '0;
        stall_mask = '1;
        mask_left  = 0;
        rd_seen    = 0;
        rd_idx     = 0;
        wr_seen    = 0;
        $readmemh("verification/fx3_stream_stimulus.txt", stim_mem);
        repeat (2) @(posedge usb_clk);
        #1;
        reset_ = 1'b1;
        repeat (2) bus_cycle();
        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            test_num   = t;
            stall_mask = stim_mem[t * TEST_WORDS];
            for (int w = 0; w < BLOCK_WORDS; w++) begin
                exp_block[w] = stim_mem[t * TEST_WORDS + 1 + w];
            end
            mask_left  = MASK_BITS;
            rd_seen    = 0;
            rd_idx     = 0;
            wr_seen    = 0;
            // offer a block on the stream-out socket
            flag_cd    = 1'b1;
            test_start = 1'b1;
            bus_cycle();
            test_start = 1'b0;
            while (!test_done && !timed_out) begin
                bus_cycle();
            end
            repeat (2) bus_cycle();
        end
        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (!timed_out && fail_cnt == 0 && pass_cnt == NUM_TESTS + 1) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
